/* verilog/pong_pkg.sv */
package pong_pkg;

    // One decimal digit in BCD
    typedef logic [3:0] bcd_digit_t;

    // Two BCD digits, tens in the upper nibble
    typedef logic [7:0] score_bcd_t;

    // Active-low segment lines, ordered {g, f, e, d, c, b, a}
    typedef logic [6:0] seg_pattern_t;

    // Game-flow states, the encoding is shown on the status LEDs
    typedef enum logic [1:0] {
        st_title = 2'd0,
        st_serve = 2'd1,
        st_rally = 2'd2,
        st_over  = 2'd3
    } game_state_t;

    // Both player scores, carried to the display scanner
    typedef struct packed {
        score_bcd_t p1;
        score_bcd_t p2;
    } score_pair_t;

    // Commands from the game FSM to the score registers
    typedef struct packed {
        logic clear;
        logic to_p1;
        logic to_p2;
    } point_req_t;

    // Winning scores in BCD
    localparam score_bcd_t MAX_SCORE_SHORT = 8'h21;
    localparam score_bcd_t MAX_SCORE_LONG  = 8'h99;

    // Digit that lights its decimal point
    localparam logic [1:0] DP_DIGIT = 2'd2;

endpackage

/* verilog/game_fsm.sv */
`timescale 1ns/1ns

module game_fsm (
    input  logic                 clk_500ms,
    input  logic                 rst_n,
    input  logic                 key_space,
    input  logic                 miss_left,
    input  logic                 miss_right,
    input  logic                 win_pending,
    output pong_pkg::game_state_t state,
    output pong_pkg::point_req_t  point_req
);

    pong_pkg::game_state_t state_d;
    logic                  point_scored;

    // Point commands are combinational so the score register
    // updates on the same edge as the state register
    always_comb begin
        point_req = '0;
        case (state)
            pong_pkg::st_title: begin
                point_req.clear = key_space;
            end
            pong_pkg::st_rally: begin
                // Right miss wins when both arrive together
                point_req.to_p1 = miss_right;
                point_req.to_p2 = miss_left & ~miss_right;
            end
            default: begin
                point_req = '0;
            end
        endcase
    end

    assign point_scored = point_req.to_p1 | point_req.to_p2;

    // Next state
    always_comb begin
        state_d = state;
        case (state)
            pong_pkg::st_title: begin
                if (key_space) begin
                    state_d = pong_pkg::st_serve;
                end
            end
            pong_pkg::st_serve: begin
                if (key_space) begin
                    state_d = pong_pkg::st_rally;
                end
            end
            pong_pkg::st_rally: begin
                // A winning point ends the game, any other point re-serves
                if (point_scored) begin
                    if (win_pending) begin
                        state_d = pong_pkg::st_over;
                    end else begin
                        state_d = pong_pkg::st_serve;
                    end
                end
            end
            pong_pkg::st_over: begin
                if (key_space) begin
                    state_d = pong_pkg::st_title;
                end
            end
            default: begin
                state_d = pong_pkg::st_title;
            end
        endcase
    end

    always_ff @(posedge clk_500ms or negedge rst_n) begin
        if (!rst_n) begin
            state <= pong_pkg::st_title;
        end else begin
            state <= state_d;
        end
    end

endmodule

/* verilog/score_keeper.sv */
`timescale 1ns/1ns

module score_keeper (
    input  logic                 clk_500ms,
    input  logic                 rst_n,
    input  logic                 sw_long_game,
    input  pong_pkg::point_req_t  point_req,
    output pong_pkg::score_pair_t scores,
    output logic                 win_pending
);

    pong_pkg::score_bcd_t max_score;
    pong_pkg::score_bcd_t p1_inc;
    pong_pkg::score_bcd_t p2_inc;
    logic                 p1_wins;
    logic                 p2_wins;

    // BCD add one, wraps from 99 back to 00
    function automatic pong_pkg::score_bcd_t bcd_inc(input pong_pkg::score_bcd_t s);
        pong_pkg::bcd_digit_t tens;
        pong_pkg::bcd_digit_t ones;
        tens = s[7:4];
        ones = s[3:0];
        if (ones == 4'd9) begin
            ones = 4'd0;
            // Carry into the tens digit
            if (tens == 4'd9) begin
                tens = 4'd0;
            end else begin
                tens = tens + 4'd1;
            end
        end else begin
            ones = ones + 4'd1;
        end
        return {tens, ones};
    endfunction

    // Switch picks the long or the short game
    assign max_score = sw_long_game ? pong_pkg::MAX_SCORE_LONG : pong_pkg::MAX_SCORE_SHORT;

    assign p1_inc = bcd_inc(scores.p1);
    assign p2_inc = bcd_inc(scores.p2);

    // Only the player receiving the current point can win with it
    assign p1_wins = point_req.to_p1 && (p1_inc == max_score);
    assign p2_wins = point_req.to_p2 && (p2_inc == max_score);

    assign win_pending = p1_wins | p2_wins;

    always_ff @(posedge clk_500ms or negedge rst_n) begin
        if (!rst_n) begin
            scores <= '0;
        end else if (point_req.clear) begin
            scores <= '0;
        end else begin
            if (point_req.to_p1) begin
                scores.p1 <= p1_inc;
            end
            if (point_req.to_p2) begin
                scores.p2 <= p2_inc;
            end
        end
    end

endmodule

/* verilog/digit_scan.sv */
`timescale 1ns/1ns

module digit_scan #(
    parameter int SCAN_DIV = 1
) (
    input  logic                  clk_500ms,
    input  logic                  rst_n,
    input  pong_pkg::score_pair_t  scores,
    output pong_pkg::seg_pattern_t seg,
    output logic                  dp,
    output logic [3:0]            an
);

    // Keep the counter at least one bit wide
    localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [CNT_W-1:0]     dwell_cnt;
    logic [1:0]           digit_idx;
    logic [1:0]           idx_d;
    logic                 step;
    pong_pkg::bcd_digit_t digit_val;

    assign step  = (dwell_cnt == CNT_W'(SCAN_DIV - 1));
    assign idx_d = step ? digit_idx + 2'd1 : digit_idx;

    // Digit 3 is the leftmost, player 1 on the left
    always_comb begin
        case (idx_d)
            2'd3:    digit_val = scores.p1[7:4];
            2'd2:    digit_val = scores.p1[3:0];
            2'd1:    digit_val = scores.p2[7:4];
            default: digit_val = scores.p2[3:0];
        endcase
    end

    always_ff @(posedge clk_500ms or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            digit_idx <= 2'd0;
        end else begin
            dwell_cnt <= step ? '0 : dwell_cnt + 1'b1;
            digit_idx <= idx_d;
        end
    end

    // Anode, segments and dot all follow the same index
    always_ff @(posedge clk_500ms or negedge rst_n) begin
        if (!rst_n) begin
            an  <= 4'b1110;
            seg <= 7'b1000000;
            dp  <= 1'b1;
        end else begin
            an <= ~(4'b0001 << idx_d);
            dp <= (idx_d != pong_pkg::DP_DIGIT);
            case (digit_val)
                4'h0:    seg <= 7'b1000000;
                4'h1:    seg <= 7'b1111001;
                4'h2:    seg <= 7'b0100100;
                4'h3:    seg <= 7'b0110000;
                4'h4:    seg <= 7'b0011001;
                4'h5:    seg <= 7'b0010010;
                4'h6:    seg <= 7'b0000010;
                4'h7:    seg <= 7'b1111000;
                4'h8:    seg <= 7'b0000000;
                4'h9:    seg <= 7'b0010000;
                4'ha:    seg <= 7'b0001000;
                4'hb:    seg <= 7'b0000011;
                4'hc:    seg <= 7'b1000110;
                4'hd:    seg <= 7'b0100001;
                4'he:    seg <= 7'b0000110;
                default: seg <= 7'b0001110;
            endcase
        end
    end

endmodule

/* verilog/status_lamps.sv */
`timescale 1ns/1ns

module status_lamps (
    input  logic                 clk_500ms,
    input  logic                 rst_n,
    input  pong_pkg::game_state_t state,
    input  logic                 sw_long_game,
    output logic [15:0]          led
);

    pong_pkg::game_state_t state_q;
    logic                  blink_q;

    always_ff @(posedge clk_500ms or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= pong_pkg::st_title;
            blink_q <= 1'b0;
        end else begin
            state_q <= state;
            // Long game holds the lamp on
            if (sw_long_game) begin
                blink_q <= 1'b1;
            end else begin
                blink_q <= ~blink_q;
            end
        end
    end

    // Middle LEDs unused
    assign led = {state_q, 13'd0, blink_q};

endmodule

/* verilog/pong_scoreboard.sv */
`timescale 1ns/1ns

module pong_scoreboard #(
    parameter int SCAN_DIV = 1
) (
    input  logic                  clk_500ms,
    input  logic                  rst_n,
    input  logic                  key_space,
    input  logic                  miss_left,
    input  logic                  miss_right,
    input  logic                  sw_long_game,
    output pong_pkg::seg_pattern_t seg,
    output logic                  dp,
    output logic [3:0]            an,
    output logic [15:0]           led
);

    pong_pkg::game_state_t state;
    pong_pkg::point_req_t  point_req;
    pong_pkg::score_pair_t scores;
    logic                  win_pending;

    // Game flow
    game_fsm u_game_fsm (
        .clk_500ms   (clk_500ms),
        .rst_n       (rst_n),
        .key_space   (key_space),
        .miss_left   (miss_left),
        .miss_right  (miss_right),
        .win_pending (win_pending),
        .state       (state),
        .point_req   (point_req)
    );

    // Score registers and win check
    score_keeper u_score_keeper (
        .clk_500ms    (clk_500ms),
        .rst_n        (rst_n),
        .sw_long_game (sw_long_game),
        .point_req    (point_req),
        .scores       (scores),
        .win_pending  (win_pending)
    );

    // Four-digit seven-segment scan
    digit_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) u_digit_scan (
        .clk_500ms (clk_500ms),
        .rst_n     (rst_n),
        .scores    (scores),
        .seg       (seg),
        .dp        (dp),
        .an        (an)
    );

    // State and blink LEDs
    status_lamps u_status_lamps (
        .clk_500ms    (clk_500ms),
        .rst_n        (rst_n),
        .state        (state),
        .sw_long_game (sw_long_game),
        .led          (led)
    );

endmodule

/* verif/tb_pong_scoreboard.sv */
`timescale 1ns/1ns

module tb_pong_scoreboard;

    localparam int SCAN_TIMEOUT = 16;
    localparam int PLAY_TIMEOUT = 4000;
    localparam int GOAL_POINTS = 0;
    localparam int GOAL_OVER = 1;
    localparam int GOAL_HIGH = 2;

    logic        clk_500ms = 1'b0;
    logic        rst_n;
    logic        key_space;
    logic        miss_left;
    logic        miss_right;
    logic        sw_long_game;
    logic [6:0]  seg;
    logic        dp;
    logic [3:0]  an;
    logic [15:0] led;

    logic [31:0]           lfsr_state;
    pong_pkg::game_state_t m_state;
    int                    m_p1;
    int                    m_p2;
    int                    errors;
    int                    test_err_start;
    int                    tests_run;
    int                    tests_failed;
    int                    dp_errors;
    int                    shown;
    int                    held;
    logic                  exp_blink;

    pong_scoreboard #(
        .SCAN_DIV (1)
    ) dut (
        .clk_500ms    (clk_500ms),
        .rst_n        (rst_n),
        .key_space    (key_space),
        .miss_left    (miss_left),
        .miss_right   (miss_right),
        .sw_long_game (sw_long_game),
        .seg          (seg),
        .dp           (dp),
        .an           (an),
        .led          (led)
    );

    always #10 clk_500ms = ~clk_500ms;

    // Dot must follow digit 2 on every cycle
    always @(negedge clk_500ms) begin
        if (rst_n) begin
            if (dp !== (an != 4'b1011)) begin
                dp_errors++;
            end
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int take_bits(input int n);
        int value;
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    // Active-low gfedcba back to a decimal digit
    function automatic logic [3:0] seg_to_digit(input logic [6:0] s);
        case (s)
            7'b1000000: return 4'd0;
            7'b1111001: return 4'd1;
            7'b0100100: return 4'd2;
            7'b0110000: return 4'd3;
            7'b0011001: return 4'd4;
            7'b0010010: return 4'd5;
            7'b0000010: return 4'd6;
            7'b1111000: return 4'd7;
            7'b0000000: return 4'd8;
            7'b0010000: return 4'd9;
            default:    return 4'hf;
        endcase
    endfunction

    // Digits 3..0 as the display should show them
    function automatic int expected_display();
        return ((m_p1 / 10) << 12) | ((m_p1 % 10) << 8) | ((m_p2 / 10) << 4) | (m_p2 % 10);
    endfunction

    function automatic logic goal_reached(input int mode, input int target, input int points);
        case (mode)
            GOAL_POINTS: return points >= target || m_state == pong_pkg::st_over;
            GOAL_OVER:   return m_state == pong_pkg::st_over;
            default:     return m_p1 >= target || m_p2 >= target;
        endcase
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_err_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - test_err_start);
        end
    endtask

    // Game rules applied at the clock edge that samples the inputs
    task automatic model_edge(input logic k, input logic ml, input logic mr);
        int max_score;
        max_score = sw_long_game ? 99 : 21;
        case (m_state)
            pong_pkg::st_title: begin
                if (k) begin
                    m_state = pong_pkg::st_serve;
                    m_p1 = 0;
                    m_p2 = 0;
                end
            end
            pong_pkg::st_serve: begin
                if (k) begin
                    m_state = pong_pkg::st_rally;
                end
            end
            pong_pkg::st_rally: begin
                // Right miss scores for player 1 and takes priority
                if (mr) begin
                    m_p1 = (m_p1 + 1) % 100;
                    m_state = (m_p1 == max_score) ? pong_pkg::st_over : pong_pkg::st_serve;
                end else if (ml) begin
                    m_p2 = (m_p2 + 1) % 100;
                    m_state = (m_p2 == max_score) ? pong_pkg::st_over : pong_pkg::st_serve;
                end
            end
            default: begin
                if (k) begin
                    m_state = pong_pkg::st_title;
                end
            end
        endcase
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic drive_cycle(input logic k, input logic ml, input logic mr);
        key_space = k;
        miss_left = ml;
        miss_right = mr;
        @(posedge clk_500ms);
        model_edge(k, ml, mr);
        #2;
        key_space = 1'b0;
        miss_left = 1'b0;
        miss_right = 1'b0;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 1'b0, 1'b0);
    endtask

    task automatic random_cycle(output logic scored);
        int   choice;
        logic both;
        logic was_rally;
        choice = take_bits(2);
        both = 1'b0;
        if (choice == 3) begin
            both = (take_bits(1) == 1);
        end
        was_rally = (m_state == pong_pkg::st_rally);
        drive_cycle(choice == 1, choice == 2 || both, choice == 3);
        scored = was_rally && choice >= 2;
    endtask

    // Watch the anodes until all four digits have been seen
    task automatic read_display(output int value);
        logic [3:0]  seen;
        logic [15:0] digits;
        int          idx;
        int          cycles;
        seen = 4'h0;
        digits = 16'h0;
        cycles = 0;
        while (seen != 4'hf && cycles < SCAN_TIMEOUT) begin
            @(posedge clk_500ms);
            #2;
            cycles++;
            for (idx = 0; idx < 4; idx++) begin
                if (an[idx] == 1'b0 && $countones(an) == 3) begin
                    seen[idx] = 1'b1;
                    digits[idx*4 +: 4] = seg_to_digit(seg);
                end
            end
        end
        for (idx = 0; idx < 4; idx++) begin
            if (!seen[idx]) begin
                $display("Error: digit %0d was never selected on the anodes", idx);
                errors++;
            end
        end
        value = int'(digits);
    endtask

    task automatic check_point(input string name);
        int value;
        idle_cycle();
        check_value({name, " state"}, int'(m_state), int'(led[15:14]));
        read_display(value);
        check_value({name, " display"}, expected_display(), value);
    endtask

    task automatic play(input int mode, input int target, input string name);
        int   points;
        int   cycles;
        logic scored;
        points = 0;
        cycles = 0;
        while (!goal_reached(mode, target, points) && cycles < PLAY_TIMEOUT) begin
            random_cycle(scored);
            cycles++;
            if (scored) begin
                points++;
                check_point(name);
                if (sw_long_game) begin
                    check_value({name, " led0"}, 1, int'(led[0]));
                end
            end
        end
        if (!goal_reached(mode, target, points)) begin
            $display("Error: %s did not reach its goal within %0d cycles", name, PLAY_TIMEOUT);
            errors++;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        key_space = 1'b0;
        miss_left = 1'b0;
        miss_right = 1'b0;
        sw_long_game = 1'b0;
        lfsr_state = 32'hdeb7_bb02;
        m_state = pong_pkg::st_title;
        m_p1 = 0;
        m_p2 = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        dp_errors = 0;
        repeat (3) @(posedge clk_500ms);
        #2;
        rst_n = 1'b1;

        begin_test();
        check_value("reset led", 0, int'(led));
        check_value("reset dp", 1, int'(dp));
        check_value("reset an", 'he, int'(an));
        read_display(shown);
        check_value("reset display", 0, shown);
        end_test("reset state");

        // State LEDs lag the state register by one cycle
        begin_test();
        drive_cycle(1'b1, 1'b0, 1'b0);
        check_value("flow title lag", int'(pong_pkg::st_title), int'(led[15:14]));
        idle_cycle();
        check_value("flow serve", int'(pong_pkg::st_serve), int'(led[15:14]));
        drive_cycle(1'b1, 1'b0, 1'b0);
        check_value("flow serve lag", int'(pong_pkg::st_serve), int'(led[15:14]));
        idle_cycle();
        check_value("flow rally", int'(pong_pkg::st_rally), int'(led[15:14]));
        end_test("game flow");

        begin_test();
        play(GOAL_POINTS, 14, "scoring");
        end_test("scoring");

        begin_test();
        play(GOAL_OVER, 0, "short game");
        read_display(held);
        check_value("short game winning score", 1, int'(held[15:8] == 8'h21 || held[7:0] == 8'h21));
        drive_cycle(1'b0, 1'b1, 1'b0);
        drive_cycle(1'b0, 1'b0, 1'b1);
        drive_cycle(1'b0, 1'b1, 1'b1);
        read_display(shown);
        check_value("scores held in over", expected_display(), shown);
        check_value("still over", int'(pong_pkg::st_over), int'(led[15:14]));
        drive_cycle(1'b1, 1'b0, 1'b0);
        check_point("back to title");
        drive_cycle(1'b1, 1'b0, 1'b0);
        check_point("clear on serve");
        end_test("short game");

        begin_test();
        sw_long_game = 1'b1;
        idle_cycle();
        idle_cycle();
        check_value("long game led0", 1, int'(led[0]));
        play(GOAL_HIGH, 23, "long game");
        check_value("long game past 21", 1, int'(led[15:14] != pong_pkg::st_over));
        read_display(shown);
        check_value("score above 21", 1, int'(shown[15:8] > 8'h21 || shown[7:0] > 8'h21));
        check_value("unused leds", 0, int'(led[13:1]));
        // Lamp was held on, so it drops on the first edge with the switch low
        sw_long_game = 1'b0;
        exp_blink = 1'b1;
        repeat (7) begin
            idle_cycle();
            exp_blink = !exp_blink;
            check_value("led0 blink", int'(exp_blink), int'(led[0]));
        end
        end_test("long game and leds");

        begin_test();
        check_value("dp follows digit 2", 0, dp_errors);
        end_test("decimal point");

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
verilog/pong_pkg.sv
verilog/game_fsm.sv
verilog/score_keeper.sv
verilog/digit_scan.sv
verilog/status_lamps.sv
verilog/pong_scoreboard.sv
verif/tb_pong_scoreboard.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the scoreboard testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_pong_scoreboard \
    --Mdir obj_dir \
    -o tb_pong_scoreboard \
    -f compile.f

./obj_dir/tb_pong_scoreboard | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
